// ==== verilog/ifetch_pkg.sv ====
package ifetch_pkg;

	// The boot flash sits outside the SDRAM window, so the first fetch is uncached.
	localparam logic [31:0] pc_reset_value = 32'h3000_0000;

	localparam logic [31:0] cached_base = 32'ha000_0000;
	localparam logic [31:0] cached_limit = 32'ha200_0000;

	localparam int line_words = 4;
	localparam int line_index_bits = 4;
	localparam int line_count = 1 << line_index_bits;

	// Bit positions inside an address, from the word offset up to the tag.
	localparam int word_offset_bits = $clog2(line_words);
	localparam int line_offset_bits = word_offset_bits + 2;
	localparam int tag_bits = 32 - line_index_bits - line_offset_bits;

	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01
	} burst_t;

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_lookup,
		fetch_addr,
		fetch_data,
		fetch_hold
	} fetch_state_t;

	// Read-address channel. len counts beats minus one.
	typedef struct packed {
		logic [31:0] addr;
		burst_t burst;
		logic [3:0] len;
	} mem_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
		logic last;
	} mem_r_t;

	// One refill word. The word with last set closes the line.
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic last;
	} cache_fill_t;

	typedef struct packed {
		logic [31:0] data;
		logic hit;
	} cache_resp_t;

endpackage

// ==== verilog/ifu.sv ====
`timescale 1ns/1ps

module ifu (
	input logic clock,
	input logic reset,

	output ifetch_pkg::mem_ar_t ar,
	output logic ar_valid,
	input logic ar_ready,
	input ifetch_pkg::mem_r_t r,
	input logic r_valid,

	output logic lookup_valid,
	output logic [31:0] lookup_addr,
	input ifetch_pkg::cache_resp_t resp,
	output logic fill_valid,
	output ifetch_pkg::cache_fill_t fill,

	input logic jump_wrong,
	input logic [31:0] jump_addr,
	input logic [31:0] dnpc,

	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic idu_valid,
	input logic idu_ready
);

	ifetch_pkg::fetch_state_t state;
	ifetch_pkg::fetch_state_t state_next;

	logic pend_redirect;
	logic [31:0] pend_addr;
	logic [ifetch_pkg::word_offset_bits-1:0] beat_count;

	logic issue;
	logic [31:0] issue_addr;
	logic issue_cached;
	logic pc_cached;
	logic beat_done;
	logic beat_match;
	logic redirect_seen;
	logic [31:0] redirect_addr;

	function automatic logic is_cached(input logic [31:0] addr);
		return addr >= ifetch_pkg::cached_base && addr < ifetch_pkg::cached_limit;
	endfunction

	assign pc_cached = is_cached(pc);
	assign issue_cached = is_cached(issue_addr);

	// A single-beat fetch ends on its only beat, a line refill on the last one.
	assign beat_done = r_valid && (r.last || !pc_cached);
	assign beat_match = !pc_cached || beat_count == pc[ifetch_pkg::line_offset_bits-1:2];

	// A redirect seen during the drain cycle counts as well as one remembered earlier.
	assign redirect_seen = jump_wrong || pend_redirect;
	assign redirect_addr = jump_wrong ? jump_addr : pend_addr;

	// A new fetch starts from idle, on an accept, or on a redirect that needs no drain.
	always_comb begin
		issue = 1'b0;
		issue_addr = pc;
		case (state)
			ifetch_pkg::fetch_idle: begin
				issue = 1'b1;
				if (jump_wrong) begin
					issue_addr = jump_addr;
				end
			end
			ifetch_pkg::fetch_lookup: begin
				if (jump_wrong) begin
					issue = 1'b1;
					issue_addr = jump_addr;
				end
			end
			ifetch_pkg::fetch_hold: begin
				if (jump_wrong) begin
					issue = 1'b1;
					issue_addr = jump_addr;
				end else if (idu_ready) begin
					issue = 1'b1;
					issue_addr = dnpc;
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		state_next = state;
		if (issue) begin
			state_next = issue_cached ? ifetch_pkg::fetch_lookup : ifetch_pkg::fetch_addr;
		end else begin
			case (state)
				ifetch_pkg::fetch_lookup: begin
					state_next = resp.hit ? ifetch_pkg::fetch_hold : ifetch_pkg::fetch_addr;
				end
				ifetch_pkg::fetch_addr: begin
					if (ar_ready) begin
						state_next = ifetch_pkg::fetch_data;
					end
				end
				ifetch_pkg::fetch_data: begin
					if (beat_done) begin
						state_next = redirect_seen ? ifetch_pkg::fetch_idle
							: ifetch_pkg::fetch_hold;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ifetch_pkg::fetch_addr;
			pc <= ifetch_pkg::pc_reset_value;
			pend_redirect <= 1'b0;
			beat_count <= '0;
		end else begin
			state <= state_next;

			if (issue) begin
				pc <= issue_addr;
			end else if (state == ifetch_pkg::fetch_data && beat_done && redirect_seen) begin
				pc <= redirect_addr;
			end

			// The request is already committed, so the redirect waits for the drain.
			if (state == ifetch_pkg::fetch_data && beat_done) begin
				pend_redirect <= 1'b0;
			end else if (jump_wrong && (state == ifetch_pkg::fetch_addr ||
					state == ifetch_pkg::fetch_data)) begin
				pend_redirect <= 1'b1;
			end

			if (ar_valid && ar_ready) begin
				beat_count <= '0;
			end else if (state == ifetch_pkg::fetch_data && r_valid) begin
				beat_count <= beat_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (jump_wrong) begin
			pend_addr <= jump_addr;
		end
		if (state == ifetch_pkg::fetch_lookup && resp.hit) begin
			inst <= resp.data;
		end else if (state == ifetch_pkg::fetch_data && r_valid && beat_match) begin
			inst <= r.data;
		end
	end

	assign ar_valid = state == ifetch_pkg::fetch_addr;

	always_comb begin
		if (pc_cached) begin
			ar.addr = {pc[31:ifetch_pkg::line_offset_bits], {ifetch_pkg::line_offset_bits{1'b0}}};
			ar.burst = ifetch_pkg::burst_incr;
			ar.len = 4'(ifetch_pkg::line_words - 1);
		end else begin
			ar.addr = pc;
			ar.burst = ifetch_pkg::burst_fixed;
			ar.len = 4'd0;
		end
	end

	assign lookup_valid = issue && issue_cached;
	assign lookup_addr = issue_addr;

	// Every refill beat goes to the cache, word addresses counting up through the line.
	assign fill_valid = state == ifetch_pkg::fetch_data && r_valid && pc_cached;
	always_comb begin
		fill.addr = {pc[31:ifetch_pkg::line_offset_bits], beat_count, 2'b00};
		fill.data = r.data;
		fill.last = r.last;
	end

	assign idu_valid = state == ifetch_pkg::fetch_hold;

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ps

module icache (
	input logic clock,
	input logic reset,

	input logic lookup_valid,
	input logic [31:0] lookup_addr,
	output ifetch_pkg::cache_resp_t resp,

	input logic fill_valid,
	input ifetch_pkg::cache_fill_t fill
);

	logic [31:0] data_mem [ifetch_pkg::line_count][ifetch_pkg::line_words];
	logic [ifetch_pkg::tag_bits-1:0] tag_mem [ifetch_pkg::line_count];
	logic [ifetch_pkg::line_count-1:0] line_valid;

	logic [ifetch_pkg::line_index_bits-1:0] lookup_index;
	logic [ifetch_pkg::word_offset_bits-1:0] lookup_offset;
	logic [ifetch_pkg::tag_bits-1:0] lookup_tag;

	logic [ifetch_pkg::line_index_bits-1:0] fill_index;
	logic [ifetch_pkg::word_offset_bits-1:0] fill_offset;
	logic [ifetch_pkg::tag_bits-1:0] fill_tag;

	logic [ifetch_pkg::line_index_bits-1:0] index_q;
	logic [ifetch_pkg::word_offset_bits-1:0] offset_q;
	logic tag_match;
	logic hit_q;

	assign lookup_offset = lookup_addr[ifetch_pkg::line_offset_bits-1:2];
	assign lookup_index = lookup_addr[ifetch_pkg::line_offset_bits +: ifetch_pkg::line_index_bits];
	assign lookup_tag = lookup_addr[31 -: ifetch_pkg::tag_bits];

	assign fill_offset = fill.addr[ifetch_pkg::line_offset_bits-1:2];
	assign fill_index = fill.addr[ifetch_pkg::line_offset_bits +: ifetch_pkg::line_index_bits];
	assign fill_tag = fill.addr[31 -: ifetch_pkg::tag_bits];

	assign tag_match = line_valid[lookup_index] && tag_mem[lookup_index] == lookup_tag;

	// A refill clears the valid bit on its first word and sets it again on the last,
	// so an evicted line stops hitting as soon as it starts to be overwritten.
	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
			hit_q <= 1'b0;
		end else begin
			hit_q <= lookup_valid && tag_match;
			if (fill_valid) begin
				line_valid[fill_index] <= fill.last;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[fill_index][fill_offset] <= fill.data;
			if (fill.last) begin
				tag_mem[fill_index] <= fill_tag;
			end
		end
	end

	// Index and offset are held so the data read lines up with the registered hit.
	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			index_q <= lookup_index;
			offset_q <= lookup_offset;
		end
	end

	assign resp.data = data_mem[index_q][offset_q];
	assign resp.hit = hit_q;

endmodule

// ==== verilog/ifetch_top.sv ====
`timescale 1ns/1ps

module ifetch_top (
	input logic clock,
	input logic reset,

	output ifetch_pkg::mem_ar_t ar,
	output logic ar_valid,
	input logic ar_ready,
	input ifetch_pkg::mem_r_t r,
	input logic r_valid,

	input logic jump_wrong,
	input logic [31:0] jump_addr,
	input logic [31:0] dnpc,

	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic idu_valid,
	input logic idu_ready
);

	logic lookup_valid;
	logic [31:0] lookup_addr;
	ifetch_pkg::cache_resp_t resp;
	logic fill_valid;
	ifetch_pkg::cache_fill_t fill;

	ifu ifu_i (
		.clock(clock),
		.reset(reset),
		.ar(ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r(r),
		.r_valid(r_valid),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.resp(resp),
		.fill_valid(fill_valid),
		.fill(fill),
		.jump_wrong(jump_wrong),
		.jump_addr(jump_addr),
		.dnpc(dnpc),
		.pc(pc),
		.inst(inst),
		.idu_valid(idu_valid),
		.idu_ready(idu_ready)
	);

	icache icache_i (
		.clock(clock),
		.reset(reset),
		.lookup_valid(lookup_valid),
		.lookup_addr(lookup_addr),
		.resp(resp),
		.fill_valid(fill_valid),
		.fill(fill)
	);

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
	input logic clock,
	input logic reset,

	input ifetch_pkg::mem_ar_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output ifetch_pkg::mem_r_t r,
	output logic r_valid,

	output ifetch_pkg::mem_ar_t last_ar,
	output int burst_count,
	output int single_count,
	output int align_errors
);

	ifetch_pkg::mem_ar_t req;
	logic valid_seen;
	int beat;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	initial begin
		void'($urandom(32'h3400_5993));
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		last_ar = '0;
		burst_count = 0;
		single_count = 0;
		align_errors = 0;
		forever begin
			@(negedge clock);
			// The request is registered in the DUT, so it already holds its value for the edge.
			valid_seen = ar_valid;
			req = ar;
			ar_ready = ($urandom % 4) != 0;
			@(posedge clock);
			if (!reset && valid_seen && ar_ready) begin
				last_ar = req;
				if (req.burst == ifetch_pkg::burst_incr) begin
					burst_count++;
					if (req.addr[3:0] != 4'h0) begin
						align_errors++;
					end
				end else begin
					single_count++;
				end
				@(negedge clock);
				ar_ready = 1'b0;
				for (beat = 0; beat <= req.len; beat++) begin
					if (req.burst == ifetch_pkg::burst_incr) begin
						r.data = word_at(req.addr + 4 * beat);
					end else begin
						r.data = word_at(req.addr);
					end
					r.resp = 2'b00;
					r.last = beat == req.len;
					r_valid = 1'b1;
					@(negedge clock);
				end
				r_valid = 1'b0;
				r.last = 1'b0;
			end
		end
	end

endmodule

// ==== testbench/ifetch_sva.sv ====
`timescale 1ns/1ps

module ifetch_sva (
	input logic clock,
	input logic reset,
	input ifetch_pkg::mem_ar_t ar,
	input logic ar_valid,
	input logic ar_ready,
	input logic jump_wrong,
	input logic [31:0] pc,
	input logic [31:0] inst,
	input logic idu_valid,
	input logic idu_ready
);

	int fail_count = 0;

	// A read request may neither change nor drop before the memory takes it.
	ar_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
	else begin
		fail_count++;
		$error("read address changed or dropped before it was accepted");
	end

	// A redirect is the only thing that may replace an offer the decoder has not taken.
	offer_hold: assert property (@(posedge clock) disable iff (reset)
		idu_valid && !idu_ready && !jump_wrong |=> idu_valid && $stable(pc) && $stable(inst))
	else begin
		fail_count++;
		$error("offered instruction changed while the decoder stalled");
	end

	redirect_flush: assert property (@(posedge clock) disable iff (reset)
		jump_wrong |=> !idu_valid)
	else begin
		fail_count++;
		$error("instruction offered in the cycle after a redirect");
	end

endmodule

bind ifetch_top ifetch_sva sva_i (.*);

// ==== testbench/ifetch_tb.sv ====
`timescale 1ns/1ps

module ifetch_tb;

	logic clock;
	logic reset;
	ifetch_pkg::mem_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	ifetch_pkg::mem_r_t r;
	logic r_valid;
	logic jump_wrong;
	logic [31:0] jump_addr;
	logic [31:0] dnpc;
	logic [31:0] pc;
	logic [31:0] inst;
	logic idu_valid;
	logic idu_ready;

	ifetch_pkg::mem_ar_t last_ar;
	int burst_count;
	int single_count;
	int align_errors;

	ifetch_top dut_i (.*);
	mem_model mem_i (.*);

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return addr ^ 32'h5a5a_0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR %s: got %h, expected %h", name, actual, expected);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// Waits at falling edges for the next offer and checks it; cycles counts the wait.
	task automatic expect_offer(input logic [31:0] exp_pc, output int cycles);
		cycles = 0;
		while (!idu_valid) begin
			@(negedge clock);
			cycles++;
		end
		check_value("pc", pc, exp_pc);
		check_value("inst", inst, word_at(exp_pc));
	endtask

	task automatic accept(input logic [31:0] next_pc);
		idu_ready = 1'b1;
		dnpc = next_pc;
		@(negedge clock);
		idu_ready = 1'b0;
	endtask

	task automatic redirect(input logic [31:0] addr);
		jump_wrong = 1'b1;
		jump_addr = addr;
		@(negedge clock);
		jump_wrong = 1'b0;
	endtask

	task automatic boot_fetch();
		logic [31:0] addr;
		int i;
		int cycles;
		addr = ifetch_pkg::pc_reset_value;
		check_value("idu_valid", idu_valid, 0);
		check_value("ar_valid", ar_valid, 1);
		check_value("ar.addr", ar.addr, addr);
		check_value("ar.burst", ar.burst, ifetch_pkg::burst_fixed);
		check_value("ar.len", ar.len, 0);
		for (i = 0; i < 10; i++) begin
			expect_offer(addr, cycles);
			check_value("single reads", single_count, i + 1);
			check_value("ar.addr", last_ar.addr, addr);
			check_value("ar.burst", last_ar.burst, ifetch_pkg::burst_fixed);
			check_value("ar.len", last_ar.len, 0);
			if (i < 9) begin
				accept(addr + 4);
			end
			addr = addr + 4;
		end
		check_value("bursts", burst_count, 0);
	endtask

	// Two line refills, then the same eight words again straight from the cache.
	task automatic line_reuse();
		logic [31:0] addr;
		int i;
		int cycles;
		int bursts;
		int singles;
		bursts = burst_count;
		singles = single_count;
		redirect(32'ha000_0100);
		addr = 32'ha000_0100;
		for (i = 0; i < 8; i++) begin
			expect_offer(addr, cycles);
			if (i % 4 == 0) begin
				check_value("ar.addr", last_ar.addr, addr);
				check_value("ar.burst", last_ar.burst, ifetch_pkg::burst_incr);
				check_value("ar.len", last_ar.len, 3);
			end
			if (i < 7) begin
				accept(addr + 4);
			end
			addr = addr + 4;
		end
		check_value("bursts", burst_count - bursts, 2);
		bursts = burst_count;
		redirect(32'ha000_0100);
		addr = 32'ha000_0100;
		for (i = 0; i < 8; i++) begin
			expect_offer(addr, cycles);
			check_value("hit latency", cycles + 1, 2);
			if (i < 7) begin
				accept(addr + 4);
			end
			addr = addr + 4;
		end
		check_value("bursts", burst_count - bursts, 0);
		check_value("single reads", single_count - singles, 0);
	endtask

	task automatic back_pressure();
		logic [31:0] addr;
		int i;
		int stall;
		int cycles;
		redirect(32'ha000_0400);
		addr = 32'ha000_0400;
		for (i = 0; i < 12; i++) begin
			expect_offer(addr, cycles);
			stall = $urandom % 6;
			repeat (stall) begin
				@(negedge clock);
				check_value("idu_valid", idu_valid, 1);
				check_value("pc", pc, addr);
				check_value("inst", inst, word_at(addr));
			end
			if (i < 11) begin
				accept(addr + 4);
			end
			addr = addr + 4;
		end
	endtask

	task automatic redirects();
		int cycles;
		int bursts;
		redirect(32'h3000_2000);
		expect_offer(32'h3000_2000, cycles);
		// The single read for 3000_2004 is already on its way when the redirect comes.
		accept(32'h3000_2004);
		redirect(32'h3000_3000);
		expect_offer(32'h3000_3000, cycles);
		bursts = burst_count;
		redirect(32'ha000_0800);
		while (burst_count == bursts) begin
			@(negedge clock);
		end
		@(negedge clock);
		redirect(32'ha000_0808);
		expect_offer(32'ha000_0808, cycles);
		// The drained burst still filled the line, so the new PC hits.
		check_value("bursts", burst_count - bursts, 1);
	endtask

	task automatic eviction();
		int cycles;
		int bursts;
		bursts = burst_count;
		redirect(32'ha000_0100);
		expect_offer(32'ha000_0100, cycles);
		redirect(32'ha000_0200);
		expect_offer(32'ha000_0200, cycles);
		check_value("bursts", burst_count - bursts, 2);
		redirect(32'ha000_0100);
		expect_offer(32'ha000_0100, cycles);
		check_value("bursts", burst_count - bursts, 3);
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Budget of 200 cycles for each instruction the tests expect.
	initial begin
		int budget;
		budget = 10 + 16 + 12 + 3 + 3;
		repeat (200 * budget) @(posedge clock);
		$display("Timeout: the fetch stage stopped delivering instructions");
		$display("Errors found");
		$fatal(1);
	end

	// A protocol assertion failure stops the run at once.
	initial begin
		wait (dut_i.sva_i.fail_count != 0);
		$display("A protocol assertion failed at %0t", $time);
		$display("Errors found");
		$fatal(1);
	end

	initial begin
		reset = 1'b1;
		jump_wrong = 1'b0;
		jump_addr = '0;
		dnpc = '0;
		idu_ready = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		boot_fetch();
		line_reuse();
		back_pressure();
		redirects();
		eviction();
		check_value("misaligned bursts", align_errors, 0);
		$display("No errors");
		$finish;
	end

endmodule

// ==== ifetch.f ====
verilog/ifetch_pkg.sv
verilog/ifu.sv
verilog/icache.sv
verilog/ifetch_top.sv
testbench/mem_model.sv
testbench/ifetch_sva.sv
testbench/ifetch_tb.sv
